/* list.f */
+incdir+src
src/mips_pkg.sv
src/mips_fetch.sv
src/mips_decoder.sv
src/mips_alu.sv
src/mips_reg_file.sv
src/mips_mem_align.sv
src/mips_cpu_harvard.sv
sim/mips_tb.sv

/* run.sh */
#!/bin/bash
# build with Verilator, run, and judge the result from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module mips_tb -f list.f -o mips_tb_sim \
    && ./obj_dir/mips_tb_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/mips_tb.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_tb
    import mips_pkg::*;
();

    localparam int n_runs = 19;  // 14 alu cases, mem, branch, halt, two jump runs
    localparam logic [4:0] r_zero = 5'd0, r_v0 = 5'd2, r_a = 5'd4, r_b = 5'd5;
    localparam logic [4:0] r_c = 5'd6, r_base = 5'd8, r_t = 5'd9, r_ra = 5'd31;

    logic  clk, reset, clk_enable, active, instr_read, data_write, data_read;
    word_t register_v0, instr_readdata, instr_address, data_address, data_writedata;
    word_t data_readdata, imem_offset;
    logic [3:0] byte_enable;

    word_t imem [256];
    word_t dmem [256];  // 0x1000 window
    word_t prog [$];

    mips_cpu_harvard i_mips_cpu_harvard (
        .clk(clk), .clk_enable(clk_enable), .reset(reset),
        .active(active), .register_v0(register_v0),
        .instr_readdata(instr_readdata), .instr_address(instr_address),
        .instr_read(instr_read),
        .byte_enable(byte_enable), .data_address(data_address), .data_write(data_write),
        .data_read(data_read), .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // outside the program window, words that must never execute
    always_comb begin
        imem_offset = instr_address - `MIPS_RESET_VECTOR;
        if (imem_offset < 32'd1024)
            instr_readdata = imem[imem_offset[9:2]];
        else if (instr_address[2])
            instr_readdata = i_op(`OP_LW, r_v0, r_base, 16'd4);  // would clobber v0
        else
            instr_readdata = i_op(`OP_SW, r_zero, r_base, 16'd0);  // would clobber memory
    end

    assign data_readdata = data_read ? dmem[data_address[9:2]] : 32'h0;

    always @(posedge clk) begin
        word_t merged;
        if (clk_enable && data_write) begin
            merged = dmem[data_address[9:2]];
            for (int k = 0; k < 4; k++)
                if (byte_enable[k])
                    merged[8*k +: 8] = data_writedata[8*k +: 8];
            dmem[data_address[9:2]] <= merged;
        end
    end

    function automatic word_t r_op(input logic [5:0] funct, input logic [4:0] rd,
                                   input logic [4:0] rs, input logic [4:0] rt,
                                   input logic [4:0] shamt);
        return {`OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t i_op(input logic [5:0] op, input logic [4:0] rt,
                                   input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_op(input logic [5:0] op, input word_t addr);
        return {op, addr[27:2]};
    endfunction

    function automatic word_t iaddr(input int idx);
        return `MIPS_RESET_VECTOR + 32'(idx * 4);
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return ~addr;
    endfunction

    function automatic word_t mem_word(input word_t addr);
        return dmem[addr[9:2]];
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
            stop_with_failure($sformatf("** Error at %0t: %s got %h, expected %h",
                                        $time, what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            stop_with_failure($sformatf("** Error at %0t: %s got %b, expected %b",
                                        $time, what, actual, expected));
    endtask

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic load_const(input logic [4:0] rt, input word_t value);
        emit(i_op(`OP_LUI, rt, r_zero, value[31:16]));
        emit(i_op(`OP_ORI, rt, rt, value[15:0]));
    endtask

    task automatic end_program();
        emit(r_op(`FN_JR, r_zero, r_zero, r_zero, 5'd0));  // jr $0 halts
        emit(32'h0);
    endtask

    // load, reset, run until active falls
    task automatic run_program(input bit stall);
        int cycles;
        int hold;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
            dmem[i] = fill_word(32'h1000 + 32'(i * 4));
        end
        reset = 1'b1;
        clk_enable = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        hold = 0;
        while (active) begin
            @(posedge clk);
            #1;
            if (active)
                check_flag(instr_read, 1'b1, "instr_read while active");
            if (stall && hold == 0 && $urandom_range(3) == 0)
                hold = int'($urandom_range(5, 1));
            clk_enable = (hold == 0);
            if (hold != 0)
                hold--;
            cycles++;
            if (cycles > 500)
                stop_with_failure("program did not halt within 500 cycles");
        end
        clk_enable = 1'b1;
        prog.delete();
    endtask

    task automatic alu_case(input word_t op, input word_t a, input word_t b,
                            input word_t expected, input string what);
        load_const(r_a, a);
        load_const(r_b, b);
        emit(op);
        end_program();
        run_program(1'b0);
        check_word(register_v0, expected, what);
    endtask

    task automatic test_alu();
        word_t a, b, sx, zx, sra_fill;
        logic [15:0] imm;
        logic [4:0] sh;
        a = $urandom();
        b = $urandom();
        imm = 16'($urandom());
        sh = 5'($urandom());
        sx = {{16{imm[15]}}, imm};
        zx = {16'h0000, imm};
        sra_fill = b[31] ? ~(32'hFFFFFFFF >> sh) : 32'h0;  // copies of the sign bit
        alu_case(r_op(`FN_ADDU, r_v0, r_a, r_b, 5'd0), a, b, a + b, "addu");
        alu_case(r_op(`FN_SUBU, r_v0, r_a, r_b, 5'd0), a, b, a - b, "subu");
        alu_case(r_op(`FN_AND, r_v0, r_a, r_b, 5'd0), a, b, a & b, "and");
        alu_case(r_op(`FN_OR, r_v0, r_a, r_b, 5'd0), a, b, a | b, "or");
        alu_case(r_op(`FN_XOR, r_v0, r_a, r_b, 5'd0), a, b, a ^ b, "xor");
        alu_case(r_op(`FN_SLT, r_v0, r_a, r_b, 5'd0), a, b,
                 ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "slt");
        alu_case(r_op(`FN_SLTU, r_v0, r_a, r_b, 5'd0), a, b, (a < b) ? 32'd1 : 32'd0, "sltu");
        alu_case(r_op(`FN_SLL, r_v0, r_zero, r_b, sh), a, b, b << sh, "sll");
        alu_case(r_op(`FN_SRL, r_v0, r_zero, r_b, sh), a, b, b >> sh, "srl");
        alu_case(r_op(`FN_SRA, r_v0, r_zero, r_b, sh), a, b, (b >> sh) | sra_fill, "sra");
        alu_case(i_op(`OP_ADDIU, r_v0, r_a, imm), a, b, a + sx, "addiu");
        alu_case(i_op(`OP_ANDI, r_v0, r_a, imm), a, b, a & zx, "andi");
        alu_case(i_op(`OP_XORI, r_v0, r_a, imm), a, b, a ^ zx, "xori");
        alu_case(i_op(`OP_SLTI, r_v0, r_a, imm), a, b,
                 ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0, "slti");
    endtask

    task automatic test_mem();
        word_t w, lanes;
        logic [7:0] bytes [4];
        logic [7:0] sbyte;
        w = $urandom();
        for (int k = 0; k < 4; k++)
            bytes[k] = 8'($urandom());
        sbyte = 8'($urandom()) | 8'h80;  // bit 7 set for lb
        emit(i_op(`OP_ORI, r_base, r_zero, 16'h1000));
        load_const(r_a, w);
        emit(i_op(`OP_SW, r_a, r_base, 16'd0));
        emit(i_op(`OP_LW, r_t, r_base, 16'd0));
        emit(i_op(`OP_SW, r_t, r_base, 16'd4));
        for (int k = 0; k < 4; k++) begin
            emit(i_op(`OP_ORI, r_b, r_zero, {8'h00, bytes[k]}));
            emit(i_op(`OP_SB, r_b, r_base, 16'(8 + k)));
        end
        emit(i_op(`OP_LW, r_t, r_base, 16'd8));
        emit(i_op(`OP_SW, r_t, r_base, 16'd12));
        emit(i_op(`OP_ORI, r_b, r_zero, {8'h00, sbyte}));
        emit(i_op(`OP_SB, r_b, r_base, 16'd17));
        emit(i_op(`OP_LB, r_t, r_base, 16'd17));
        emit(i_op(`OP_SW, r_t, r_base, 16'd20));
        emit(i_op(`OP_LBU, r_v0, r_base, 16'd17));
        end_program();
        run_program(1'b0);
        lanes = fill_word(32'h1010);
        lanes[23:16] = sbyte;  // byte 1 is second from the top
        check_word(mem_word(32'h1000), w, "sw word");
        check_word(mem_word(32'h1004), w, "lw after sw");
        check_word(mem_word(32'h100C), {bytes[0], bytes[1], bytes[2], bytes[3]}, "sb lanes");
        check_word(mem_word(32'h1010), lanes, "sb leaves other lanes");
        check_word(mem_word(32'h1014), {24'hFFFFFF, sbyte}, "lb sign extension");
        check_word(register_v0, {24'h000000, sbyte}, "lbu zero extension");
    endtask

    task automatic test_branch();
        load_const(r_v0, 32'h0);
        emit(i_op(`OP_ORI, r_a, r_zero, 16'd5));
        emit(i_op(`OP_ORI, r_b, r_zero, 16'd5));
        emit(i_op(`OP_ORI, r_c, r_zero, 16'd7));
        emit(i_op(`OP_BEQ, r_b, r_a, 16'd2));       // taken
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd1));
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd100)); // skipped
        emit(i_op(`OP_BEQ, r_c, r_a, 16'd2));       // not taken
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd1));
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd1));
        emit(i_op(`OP_BNE, r_c, r_a, 16'd2));       // taken
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd1));
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd100));
        emit(i_op(`OP_BNE, r_b, r_a, 16'd2));       // not taken
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd1));
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'd1));
        end_program();
        run_program(1'b0);
        // four slots plus two fall-through increments
        check_word(register_v0, 32'd6, "branch and delay slot count");
    endtask

    task automatic test_jumps(input bit stall);
        emit(i_op(`OP_ORI, r_base, r_zero, 16'h1000));       // 0
        emit(j_op(`OP_J, iaddr(4)));                         // 1
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'h0001));         // 2, slot
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'h1000));         // 3, skipped
        emit(j_op(`OP_JAL, iaddr(9)));                       // 4
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'h0001));         // 5, slot
        emit(i_op(`OP_SW, r_ra, r_base, 16'd0));             // 6, return lands here
        end_program();                                       // 7, 8
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'h0010));         // 9, subroutine
        emit(r_op(`FN_JR, r_zero, r_ra, r_zero, 5'd0));      // 10
        emit(i_op(`OP_ADDIU, r_v0, r_v0, 16'h0100));         // 11, slot
        run_program(stall);
        check_word(register_v0, 32'h112, stall ? "v0 with stalls" : "v0 after jumps");
        check_word(mem_word(32'h1000), iaddr(4) + 32'd8, "jal link address");
    endtask

    task automatic test_halt();
        word_t v0_seen, mem_seen;
        logic [15:0] value;
        value = 16'($urandom()) | 16'h0001;  // never equal to a cleared word
        emit(i_op(`OP_ORI, r_v0, r_zero, value));
        emit(i_op(`OP_ORI, r_base, r_zero, 16'h1000));
        emit(i_op(`OP_SW, r_v0, r_base, 16'd0));
        end_program();
        run_program(1'b0);
        check_word(register_v0, {16'h0000, value}, "v0 at halt");
        check_word(mem_word(32'h1000), {16'h0000, value}, "stored word at halt");
        v0_seen = register_v0;
        mem_seen = mem_word(32'h1000);
        repeat (20) begin
            @(posedge clk);
            #1;
            check_flag(active, 1'b0, "active after halt");
            check_flag(instr_read, 1'b0, "instr_read after halt");
            check_flag(data_read, 1'b0, "data_read after halt");
            check_flag(data_write, 1'b0, "data_write after halt");
            check_word(register_v0, v0_seen, "v0 held after halt");
            check_word(mem_word(32'h1000), mem_seen, "memory held after halt");
        end
    endtask

    initial begin
        #(n_runs * 500 * 4 + 1000);
        stop_with_failure("watchdog expired before all tests finished");
    end

    initial begin
        reset = 1'b1;
        clk_enable = 1'b1;
        void'($urandom(94914));
        test_alu();
        test_mem();
        test_branch();
        test_jumps(1'b0);
        test_halt();
        test_jumps(1'b1);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* src/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
    import mips_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    input  alu_op_t    alu_op,
    input  logic       branch_ne,
    output word_t      result,
    output logic       branch_taken
);

    logic lt_signed, lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_LUI:  result = b;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            // shifts act on rt, amount from the shamt field
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            default:  result = a + b;
        endcase
    end

    // only looked at by fetch for BEQ/BNE
    assign branch_taken = (a == b) ^ branch_ne;

endmodule

/* src/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_cpu_harvard
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        clk_enable,
    input  logic        reset,

    output logic        active,
    output logic [31:0] register_v0,

    // instruction side
    input  logic [31:0] instr_readdata,
    output logic [31:0] instr_address,
    output logic        instr_read,

    // data side
    output logic [3:0]  byte_enable,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    instr_t     instr;
    word_t      link_pc, reg_a, reg_b, alu_b, alu_result, load_data, write_data, imm;
    alu_op_t    alu_op;
    pc_sel_t    pc_sel;
    wb_sel_t    wb_sel;
    mem_size_t  mem_size;
    logic [4:0] write_reg;
    logic       reg_write, use_imm, branch_ne, load_signed, branch_taken, executing;

    assign instr      = instr_readdata;
    assign instr_read = active;
    assign executing  = active && (instr_address != `MIPS_HALT_ADDR);  // word at 0 never runs

    assign alu_b = use_imm ? imm : reg_b;

    always_comb begin
        case (wb_sel)
            WB_LOAD: write_data = load_data;
            WB_LINK: write_data = link_pc;  // JAL, pc + 8
            default: write_data = alu_result;
        endcase
    end

    mips_fetch fetch_1 (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .pc_sel(pc_sel),
        .branch_taken(branch_taken),
        .branch_offset(imm),
        .jump_target(instr.j.target26),
        .jump_reg(reg_a),
        .pc(instr_address),
        .link_pc(link_pc),
        .active(active)
    );

    mips_decoder decoder_1 (
        .instr(instr),
        .active(executing),
        .alu_op(alu_op),
        .pc_sel(pc_sel),
        .wb_sel(wb_sel),
        .mem_size(mem_size),
        .reg_write(reg_write),
        .write_reg(write_reg),
        .use_imm(use_imm),
        .imm(imm),
        .branch_ne(branch_ne),
        .load_signed(load_signed),
        .data_read(data_read),
        .data_write(data_write)
    );

    mips_alu alu_1 (
        .a(reg_a),
        .b(alu_b),
        .shamt(instr.r.shamt),
        .alu_op(alu_op),
        .branch_ne(branch_ne),
        .result(alu_result),
        .branch_taken(branch_taken)
    );

    mips_reg_file reg_file_1 (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .read_reg1(instr.r.rs),
        .read_reg2(instr.r.rt),
        .read_data_a(reg_a),
        .read_data_b(reg_b),
        .write_reg(write_reg),
        .write_enable(reg_write),
        .write_data(write_data),
        .register_v0(register_v0)
    );

    mips_mem_align mem_align_1 (
        .address(alu_result),
        .mem_size(mem_size),
        .load_signed(load_signed),
        .store_data(reg_b),
        .data_read(data_read),
        .data_write(data_write),
        .data_readdata(data_readdata),
        .data_address(data_address),
        .byte_enable(byte_enable),
        .data_writedata(data_writedata),
        .load_data(load_data)
    );

endmodule

/* src/mips_decoder.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_decoder
    import mips_pkg::*;
(
    input  instr_t      instr,
    input  logic        active,
    output alu_op_t     alu_op,
    output pc_sel_t     pc_sel,
    output wb_sel_t     wb_sel,
    output mem_size_t   mem_size,
    output logic        reg_write,
    output logic [4:0]  write_reg,
    output logic        use_imm,
    output word_t       imm,
    output logic        branch_ne,
    output logic        load_signed,
    output logic        data_read,
    output logic        data_write
);

    logic [5:0] opcode;
    logic       zero_ext, upper_imm;

    assign opcode = instr.j.opcode;

    always_comb begin
        alu_op      = ALU_ADD;
        pc_sel      = PC_SEQ;
        wb_sel      = WB_ALU;
        mem_size    = MEM_WORD;
        reg_write   = 1'b0;
        write_reg   = instr.i.rt;  // I format unless overridden
        use_imm     = 1'b1;
        branch_ne   = 1'b0;
        load_signed = 1'b0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        zero_ext    = 1'b0;
        upper_imm   = 1'b0;

        case (opcode)
            `OP_SPECIAL: begin
                write_reg = instr.r.rd;
                use_imm   = 1'b0;
                reg_write = 1'b1;
                case (instr.r.funct)
                    `FN_SLL:  alu_op = ALU_SLL;
                    `FN_SRL:  alu_op = ALU_SRL;
                    `FN_SRA:  alu_op = ALU_SRA;
                    `FN_ADDU: alu_op = ALU_ADD;
                    `FN_SUBU: alu_op = ALU_SUB;
                    `FN_AND:  alu_op = ALU_AND;
                    `FN_OR:   alu_op = ALU_OR;
                    `FN_XOR:  alu_op = ALU_XOR;
                    `FN_SLT:  alu_op = ALU_SLT;
                    `FN_SLTU: alu_op = ALU_SLTU;
                    `FN_JR: begin
                        reg_write = 1'b0;
                        pc_sel    = PC_REG;
                    end
                    default:  reg_write = 1'b0;  // unknown funct is a no-op
                endcase
            end
            `OP_J:   pc_sel = PC_JUMP;
            `OP_JAL: begin
                pc_sel    = PC_JUMP;
                reg_write = 1'b1;
                write_reg = 5'd31;
                wb_sel    = WB_LINK;
            end
            `OP_BEQ, `OP_BNE: begin
                pc_sel    = PC_BRANCH;
                use_imm   = 1'b0;  // compare rs with rt
                branch_ne = (opcode == `OP_BNE);
            end
            `OP_ADDIU: reg_write = 1'b1;
            `OP_SLTI: begin
                reg_write = 1'b1;
                alu_op    = ALU_SLT;
            end
            `OP_SLTIU: begin
                reg_write = 1'b1;
                alu_op    = ALU_SLTU;  // sign-extended, compared unsigned
            end
            `OP_ANDI: begin
                reg_write = 1'b1;
                alu_op    = ALU_AND;
                zero_ext  = 1'b1;
            end
            `OP_ORI: begin
                reg_write = 1'b1;
                alu_op    = ALU_OR;
                zero_ext  = 1'b1;
            end
            `OP_XORI: begin
                reg_write = 1'b1;
                alu_op    = ALU_XOR;
                zero_ext  = 1'b1;
            end
            `OP_LUI: begin
                reg_write = 1'b1;
                alu_op    = ALU_LUI;
                upper_imm = 1'b1;
            end
            `OP_LB, `OP_LBU, `OP_LW: begin
                reg_write   = 1'b1;
                wb_sel      = WB_LOAD;
                data_read   = 1'b1;
                mem_size    = (opcode == `OP_LW) ? MEM_WORD : MEM_BYTE;
                load_signed = (opcode == `OP_LB);
            end
            `OP_SB, `OP_SW: begin
                data_write = 1'b1;
                mem_size   = (opcode == `OP_SW) ? MEM_WORD : MEM_BYTE;
            end
            default: use_imm = 1'b0;
        endcase

        // nothing commits once halted
        if (!active) begin
            reg_write  = 1'b0;
            data_read  = 1'b0;
            data_write = 1'b0;
        end
    end

    assign imm = upper_imm ? {instr.i.imm16, 16'h0000} :
                 zero_ext  ? {16'h0000, instr.i.imm16} :
                             {{16{instr.i.imm16[15]}}, instr.i.imm16};

endmodule

/* src/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// boot and halt addresses
`define MIPS_RESET_VECTOR 32'hBFC00000
`define MIPS_HALT_ADDR    32'h00000000

// primary opcodes, instr[31:26]
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0A
`define OP_SLTIU   6'h0B
`define OP_ANDI    6'h0C
`define OP_ORI     6'h0D
`define OP_XORI    6'h0E
`define OP_LUI     6'h0F
`define OP_LB      6'h20
`define OP_LW      6'h23
`define OP_LBU     6'h24
`define OP_SB      6'h28
`define OP_SW      6'h2B

// funct field for OP_SPECIAL, instr[5:0]
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_SRA  6'h03
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2A
`define FN_SLTU 6'h2B

`endif

/* src/mips_fetch.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_fetch
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  pc_sel_t     pc_sel,
    input  logic        branch_taken,
    input  word_t       branch_offset,
    input  logic [25:0] jump_target,
    input  word_t       jump_reg,
    output word_t       pc,
    output word_t       link_pc,
    output logic        active
);

    word_t slot_pc, branch_target, jump_addr, target, next_pc, pending_pc;
    logic  redirect, pending, update;

    assign update  = clk_enable & active;  // halted core holds its state
    assign slot_pc = pc + 32'd4;
    assign link_pc = pc + 32'd8;

    // targets are relative to the delay slot
    assign branch_target = slot_pc + {branch_offset[29:0], 2'b00};
    assign jump_addr     = {slot_pc[31:28], jump_target, 2'b00};

    always_comb begin
        redirect = 1'b0;
        target   = branch_target;
        case (pc_sel)
            PC_BRANCH: redirect = branch_taken;
            PC_JUMP: begin
                redirect = 1'b1;
                target   = jump_addr;
            end
            PC_REG: begin
                redirect = 1'b1;
                target   = jump_reg;
            end
            default: ;
        endcase
    end

    assign next_pc = pending ? pending_pc : slot_pc;  // slot done, go to target

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `MIPS_RESET_VECTOR;
            pending <= 1'b0;
            active  <= 1'b1;
        end else if (update) begin
            pc      <= next_pc;
            pending <= redirect;
            if (pc == `MIPS_HALT_ADDR)
                active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (update && redirect)
            pending_pc <= target;
    end

    assert property (@(posedge clk) disable iff (reset) active |-> pc[1:0] == 2'b00)
        else $error("fetch from unaligned pc %h", pc);

endmodule

/* src/mips_mem_align.sv */
`timescale 1ns/1ps

module mips_mem_align
    import mips_pkg::*;
(
    input  word_t      address,
    input  mem_size_t  mem_size,
    input  logic       load_signed,
    input  word_t      store_data,
    input  logic       data_read,
    input  logic       data_write,
    input  word_t      data_readdata,
    output word_t      data_address,
    output logic [3:0] byte_enable,
    output word_t      data_writedata,
    output word_t      load_data
);

    logic [1:0] offset;
    logic [7:0] lane;

    assign offset       = address[1:0];
    assign data_address = {address[31:2], 2'b00};

    // big endian, offset 0 is bits 31:24
    assign byte_enable = (data_write && mem_size == MEM_BYTE) ? (4'b1000 >> offset) : 4'b1111;

    assign data_writedata = (mem_size == MEM_BYTE) ? {4{store_data[7:0]}} : store_data;

    always_comb begin
        case (offset)
            2'd0:    lane = data_readdata[31:24];
            2'd1:    lane = data_readdata[23:16];
            2'd2:    lane = data_readdata[15:8];
            default: lane = data_readdata[7:0];
        endcase
    end

    assign load_data = (mem_size == MEM_WORD) ? data_readdata :
                       {{24{load_signed & lane[7]}}, lane};

    always_comb begin
        assert final (!((data_read || data_write) && mem_size == MEM_WORD && offset != 2'd0))
            else $error("unaligned word access at %h", address);
    end

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    // one fetched word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,   // passes b, immediate already shifted
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;

    typedef enum logic {MEM_BYTE, MEM_WORD} mem_size_t;

endpackage

/* src/mips_reg_file.sv */
`timescale 1ns/1ps

module mips_reg_file
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       clk_enable,
    input  logic [4:0] read_reg1,
    input  logic [4:0] read_reg2,
    output word_t      read_data_a,
    output word_t      read_data_b,
    input  logic [4:0] write_reg,
    input  logic       write_enable,
    input  word_t      write_data,
    output word_t      register_v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (clk_enable && write_enable && write_reg != 5'd0) begin
            regs[write_reg] <= write_data;  // $zero never written
        end
    end

    assign read_data_a = regs[read_reg1];
    assign read_data_b = regs[read_reg2];
    assign register_v0 = regs[2];

endmodule
